//--- sim.f
+incdir+include
hw/ctrlPkg.sv
hw/aluDecoder.sv
hw/stateSequencer.sv
hw/controlDecoder.sv
hw/multicycleController.sv
verif/tb_multicycleController.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the controller testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f \
    --top-module tb_multicycleController -Mdir obj_dir

./obj_dir/Vtb_multicycleController | tee sim.log

if grep -q "^Test passed$" sim.log; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1

//--- include/ctrlModel.svh
// ***************************************
// reference model for the controller: ALU
// op, state walk and expected control word
// ***************************************
`ifndef CTRL_MODEL_SVH
`define CTRL_MODEL_SVH

// ctrlPkg must be imported by the including scope

// returns 1 for a supported instruction, op gets its ALU code
function automatic logic modelAluOp(input instrFields_t i, output aluOp_e op);
    logic legal;
    legal = 1'b1;
    op    = ADD;
    case (i.opcode)
        LOAD, STORE, BRANCH, NOP: op = ADD;
        OPREG:
        begin
            case ({i.funct7, i.funct3})
                {FUNCT7_BASE, F3_ADD}: op = ADD;
                {FUNCT7_ALT, F3_ADD}:  op = SUB;
                {FUNCT7_BASE, F3_SLT}: op = SLT;
                {FUNCT7_BASE, F3_OR}:  op = OR;
                {FUNCT7_BASE, F3_AND}: op = AND;
                default:               legal = 1'b0;
            endcase
        end
        OPIMM:
        begin
            case (i.funct3)
                F3_ADD:  op = ADD;
                F3_SLT:  op = SLT;
                F3_OR:   op = OR;
                F3_AND:  op = AND;
                default: legal = 1'b0;
            endcase
        end
        // jal and unknown opcodes
        default: legal = 1'b0;
    endcase
    return legal;
endfunction

// expected state at cycle step, counted from FETCH
// past the end of the walk the next FETCH is expected, illegal stays in FAULT
function automatic ctrlState_e modelState(input instrFields_t i, input int step);
    aluOp_e     op;
    logic       legal;
    ctrlState_e walk [2:4];
    walk[2] = FETCH;
    walk[3] = FETCH;
    walk[4] = FETCH;
    legal   = modelAluOp(i, op);
    case (i.opcode)
        LOAD:
        begin
            walk[2] = MEMADDR;
            walk[3] = MEMREAD;
            walk[4] = MEMWB;
        end
        STORE:
        begin
            walk[2] = MEMADDR;
            walk[3] = MEMWRITE;
        end
        OPREG:
        begin
            walk[2] = EXECR;
            walk[3] = ALUWB;
        end
        OPIMM:
        begin
            walk[2] = EXECI;
            walk[3] = ALUWB;
        end
        BRANCH:
        begin
            walk[2] = BEQ;
            walk[3] = BRANCHCHECK;
        end
        default: walk[2] = FETCH;
    endcase
    if (step <= 0)
        return FETCH;
    if (step == 1)
        return DECODE;
    if (!legal)
        return FAULT;
    if (step > 4)
        return FETCH;
    return walk[step];
endfunction

// expected Moore output for a state, written out field by field
function automatic ctrlWord_t modelCtrl(input ctrlState_e st, input aluOp_e heldOp,
                                        input logic zero);
    ctrlWord_t w;
    w = '0;
    case (st)
        FETCH:
        begin
            w.pcWrite    = 1'b1;
            w.irWrite    = 1'b1;
            w.aluSrcA    = A_PC;
            w.aluSrcB    = B_FOUR;
            w.aluControl = ADD;
            w.resultSrc  = ALURESULT;
        end
        MEMADDR:
        begin
            w.aluSrcA = A_REG;
            w.aluSrcB = B_IMM;
            w.immSrc  = STYPE;
        end
        MEMREAD:
        begin
            w.adrSrc    = 1'b1;
            w.resultSrc = ALUOUT;
        end
        MEMWRITE:
        begin
            w.adrSrc    = 1'b1;
            w.memWrite  = 1'b1;
            w.resultSrc = ALURESULT;
        end
        MEMWB:
        begin
            w.regWrite  = 1'b1;
            w.resultSrc = DATA;
        end
        EXECR:
        begin
            w.aluSrcA    = A_REG;
            w.aluControl = heldOp;
        end
        EXECI:
        begin
            w.aluSrcA    = A_REG;
            w.aluSrcB    = B_IMM;
            w.aluControl = heldOp;
        end
        ALUWB: w.regWrite = 1'b1;
        BEQ:
        begin
            w.aluSrcA    = A_REG;
            w.aluControl = SUB;
        end
        BRANCHCHECK:
        begin
            if (zero)
            begin
                w.pcWrite   = 1'b1;
                w.aluSrcA   = A_OLDPC;
                w.aluSrcB   = B_IMM;
                w.resultSrc = ALURESULT;
                w.immSrc    = BTYPE;
            end
        end
        default: w = '0;
    endcase
    return w;
endfunction

`endif

//--- verif/tb_multicycleController.sv
// ***************************************
// testbench for the multicycle controller
// with instruction walks checked every cycle
// ***************************************
`timescale 1ns/1ps

module tb_multicycleController
    import ctrlPkg::*;
;

    `include "ctrlModel.svh"

    localparam int WAIT_LIMIT = 20;

    logic         clk = 1'b0;
    logic         reset;
    instrFields_t instr;
    logic         zero;
    ctrlWord_t    ctrl;
    ctrlState_e   state;
    logic         fault;

    // expected side is written 5 ns after the edge and read at negedge
    instrFields_t curInstr;
    logic         curZero;
    int           step;
    int           errCount;
    int           passCount;
    int           failCount;
    logic [15:0]  lfsrState = 16'd566;

    multicycleController u_multicycleController (
        .clk   (clk),
        .reset (reset),
        .instr (instr),
        .zero  (zero),
        .ctrl  (ctrl),
        .state (state),
        .fault (fault)
    );

    always #20 clk = ~clk;

    // galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsrState = lfsrNext(lfsrState);
            r = {r[30:0], lfsrState[0]};
        end
        return r;
    endfunction

    // supported funct3 codes only
    function automatic logic [2:0] pickFunct3();
        case (randBits(2))
            0:       return 3'b000;
            1:       return 3'b010;
            2:       return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    function automatic instrFields_t randomRType();
        instrFields_t f;
        logic [31:0]  b;
        f.opcode = OPREG;
        f.funct3 = pickFunct3();
        b = randBits(1);
        // sub only exists on the add code
        f.funct7 = (f.funct3 == 3'b000 && b[0]) ? 7'b0100000 : 7'b0000000;
        return f;
    endfunction

    function automatic instrFields_t randomIType();
        instrFields_t f;
        logic [31:0]  b;
        f.opcode = OPIMM;
        f.funct3 = pickFunct3();
        // upper immediate bits may take any value
        b = randBits(7);
        f.funct7 = b[6:0];
        return f;
    endfunction

    task automatic checkCtrl(input ctrlWord_t got, input ctrlWord_t exp, input string what);
        if (got !== exp)
        begin
            $display("[FAIL] %0t ns: ctrl in %s got %h expected %h", $time, what, got, exp);
            errCount++;
        end
    endtask

    task automatic checkState(input ctrlState_e got, input ctrlState_e exp, input string what);
        if (got !== exp)
        begin
            $display("[FAIL] %0t ns: state at %s got %s expected %s",
                     $time, what, got.name(), exp.name());
            errCount++;
        end
    endtask

    task automatic checkFault(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("[FAIL] %0t ns: fault at %s got %b expected %b", $time, what, got, exp);
            errCount++;
        end
    endtask

    // compare every cycle in the middle of the clock period
    always @(negedge clk)
    begin
        ctrlState_e expState;
        aluOp_e     expOp;
        expState = modelState(curInstr, step);
        void'(modelAluOp(curInstr, expOp));
        checkState(state, expState, "cycle check");
        checkCtrl(ctrl, modelCtrl(expState, expOp, curZero), expState.name());
        checkFault(fault, expState == FAULT, "cycle check");
    end

    task automatic finishRun();
        $display("tests: %0d ok, %0d with errors, %0d mismatches", passCount, failCount,
                 errCount);
        if (errCount == 0 && failCount == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    endtask

    task automatic endTest(input string name, input int errBefore);
        if (errCount == errBefore)
        begin
            passCount++;
            $display("test %-12s ok", name);
        end
        else
        begin
            failCount++;
            $display("test %-12s %0d mismatches", name, errCount - errBefore);
        end
    endtask

    // reset for 3 cycles and return 5 ns after the edge in FETCH
    task automatic applyReset();
        reset    = 1'b1;
        curInstr = '0;
        curZero  = 1'b0;
        step     = 0;
        for (int c = 0; c < 3; c++)
        begin
            @(posedge clk);
            #5;
        end
        reset = 1'b0;
    endtask

    // step keeps counting while the FSM stays in FAULT
    task automatic holdCycles(input int n);
        for (int c = 0; c < n; c++)
        begin
            @(posedge clk);
            #5;
            step++;
        end
    endtask

    // start in FETCH and wait for the next FETCH or for FAULT
    task automatic runInstr(input instrFields_t i, input logic z);
        int          cycles;
        logic        legal;
        aluOp_e      op;
        logic [31:0] junk;
        ctrlState_e  target;
        legal    = modelAluOp(i, op);
        target   = legal ? FETCH : FAULT;
        instr    = i;
        zero     = z;
        curInstr = i;
        curZero  = z;
        step     = 0;
        cycles   = 0;
        do
        begin
            @(posedge clk);
            #5;
            step++;
            cycles++;
            // after decode the latched class and ALU op must carry on
            if (step == 2 && state != FETCH)
            begin
                junk  = randBits(17);
                instr = junk[16:0];
            end
        end
        while (state != target && cycles < WAIT_LIMIT);
        if (state != target)
        begin
            $display("timeout: state %s never reached %s for opcode %b",
                     state.name(), target.name(), i.opcode);
            errCount++;
        end
    endtask

    initial
    begin
        int           errBefore;
        instrFields_t f;
        logic [31:0]  b;
        reset     = 1'b1;
        instr     = '0;
        zero      = 1'b0;
        curInstr  = '0;
        curZero   = 1'b0;
        step      = 0;
        errCount  = 0;
        passCount = 0;
        failCount = 0;

        errBefore = errCount;
        applyReset();
        checkState(state, FETCH, "after reset");
        checkCtrl(ctrl, modelCtrl(FETCH, ADD, 1'b0), "after reset");
        checkFault(fault, 1'b0, "after reset");
        endTest("reset", errBefore);

        errBefore = errCount;
        runInstr('{opcode: LOAD, funct3: 3'b010, funct7: 7'h00}, 1'b0);
        runInstr('{opcode: STORE, funct3: 3'b010, funct7: 7'h00}, 1'b0);
        runInstr('{opcode: LOAD, funct3: 3'b010, funct7: 7'h15}, 1'b1);
        endTest("lw_sw", errBefore);

        errBefore = errCount;
        for (int n = 0; n < 8; n++)
        begin
            runInstr(randomRType(), 1'b0);
            runInstr(randomIType(), 1'b0);
        end
        endTest("alu_ops", errBefore);

        errBefore = errCount;
        for (int n = 0; n < 6; n++)
        begin
            b = randBits(1);
            runInstr('{opcode: BRANCH, funct3: 3'b000, funct7: 7'h00}, b[0]);
        end
        // taken and not taken at least once each
        runInstr('{opcode: BRANCH, funct3: 3'b000, funct7: 7'h00}, 1'b1);
        runInstr('{opcode: BRANCH, funct3: 3'b000, funct7: 7'h00}, 1'b0);
        runInstr('0, 1'b0);
        endTest("beq_nop", errBefore);

        // jal, xori and an unknown opcode are each cleared by reset
        errBefore = errCount;
        for (int n = 0; n < 3; n++)
        begin
            f = '0;
            case (n)
                0: f.opcode = JAL;
                1:
                begin
                    f.opcode = OPIMM;
                    f.funct3 = 3'b100;
                end
                default: f.opcode = 7'b1111111;
            endcase
            runInstr(f, 1'b0);
            holdCycles(3);
            applyReset();
            runInstr(randomRType(), 1'b0);
        end
        endTest("illegal", errBefore);

        finishRun();
    end

endmodule

//--- hw/multicycleController.sv
// ***************************************
// multicycle RISC-V controller top: ALU
// decoder, state sequencer, control decoder
// ***************************************
`timescale 1ns/1ps

module multicycleController
    import ctrlPkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  instrFields_t instr,
    input  logic         zero,
    output ctrlWord_t    ctrl,
    output ctrlState_e   state,
    output logic         fault
);

    aluOp_e aluOp;
    logic   illegal;
    aluOp_e heldAluOp;

    // combinational decode of the instruction register fields
    aluDecoder u_aluDecoder (
        .instr   (instr),
        .aluOp   (aluOp),
        .illegal (illegal)
    );

    // isStore only steers MEMADDR inside the sequencer
    stateSequencer u_stateSequencer (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .aluOp     (aluOp),
        .illegal   (illegal),
        .state     (state),
        .heldAluOp (heldAluOp),
        .isStore   ()
    );

    controlDecoder u_controlDecoder (
        .state     (state),
        .heldAluOp (heldAluOp),
        .zero      (zero),
        .ctrl      (ctrl)
    );

    assign fault = (state == FAULT);

endmodule

//--- hw/controlDecoder.sv
// ***************************************
// control decoder: Moore output word from
// the current state and held ALU op
// ***************************************
`timescale 1ns/1ps

module controlDecoder
    import ctrlPkg::*;
(
    input  ctrlState_e state,
    input  aluOp_e     heldAluOp,
    input  logic       zero,
    output ctrlWord_t  ctrl
);

    always_comb
    begin
        // every field not named below stays at its zero code
        ctrl = IDLE_WORD;
        case (state)
            FETCH:
            begin
                ctrl = FETCH_WORD;
            end
            DECODE:
            begin
                // idle, decode is settled inside the sequencer
                ctrl = IDLE_WORD;
            end
            MEMADDR:
            begin
                // rs1 + S-type offset
                ctrl.aluSrcA    = A_REG;
                ctrl.aluSrcB    = B_IMM;
                ctrl.aluControl = ADD;
                ctrl.immSrc     = STYPE;
            end
            MEMREAD:
            begin
                // ALUOut drives the memory address
                ctrl.adrSrc    = 1'b1;
                ctrl.resultSrc = ALUOUT;
            end
            MEMWRITE:
            begin
                ctrl.adrSrc    = 1'b1;
                ctrl.memWrite  = 1'b1;
                ctrl.resultSrc = ALURESULT;
            end
            MEMWB:
            begin
                // data register into rd
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = DATA;
            end
            EXECR:
            begin
                ctrl.aluSrcA    = A_REG;
                ctrl.aluSrcB    = B_REG;
                ctrl.aluControl = heldAluOp;
            end
            EXECI:
            begin
                ctrl.aluSrcA    = A_REG;
                ctrl.aluSrcB    = B_IMM;
                ctrl.aluControl = heldAluOp;
                ctrl.immSrc     = ITYPE;
            end
            ALUWB:
            begin
                // ALUOut into rd
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = ALUOUT;
            end
            BEQ:
            begin
                // rs1 - rs2, zero flag valid next cycle
                ctrl.aluSrcA    = A_REG;
                ctrl.aluSrcB    = B_REG;
                ctrl.aluControl = SUB;
            end
            BRANCHCHECK:
            begin
                // taken: PC <= oldPC + B-type offset
                if (zero)
                begin
                    ctrl.pcWrite    = 1'b1;
                    ctrl.aluSrcA    = A_OLDPC;
                    ctrl.aluSrcB    = B_IMM;
                    ctrl.aluControl = ADD;
                    ctrl.resultSrc  = ALURESULT;
                    ctrl.immSrc     = BTYPE;
                end
            end
            FAULT:
            begin
                ctrl = IDLE_WORD;
            end
            default:
            begin
                ctrl = IDLE_WORD;
            end
        endcase

        // memory and register file never written in the same cycle
        assert (!(ctrl.memWrite && ctrl.regWrite))
        else $error("memWrite and regWrite high together");
    end

endmodule

//--- hw/stateSequencer.sv
// ***************************************
// state sequencer: Moore FSM state register
// and next-state table, latches the ALU op
// and load/store class at decode
// ***************************************
`timescale 1ns/1ps

module stateSequencer
    import ctrlPkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  instrFields_t instr,
    input  aluOp_e       aluOp,
    input  logic         illegal,
    output ctrlState_e   state,
    output aluOp_e       heldAluOp,
    output logic         isStore
);

    ctrlState_e nextState;

    // next-state table, one state per clock
    always_comb
    begin
        nextState = FAULT;
        case (state)
            FETCH:
            begin
                nextState = DECODE;
            end
            DECODE:
            begin
                // illegal funct or opcode wins over the opcode branch
                if (illegal)
                begin
                    nextState = FAULT;
                end
                else
                begin
                    case (instr.opcode)
                        LOAD, STORE: nextState = MEMADDR;
                        OPREG:       nextState = EXECR;
                        OPIMM:       nextState = EXECI;
                        BRANCH:      nextState = BEQ;
                        // nop is done after decode
                        NOP:         nextState = FETCH;
                        default:     nextState = FAULT;
                    endcase
                end
            end
            MEMADDR:
            begin
                // class was captured at decode, instr may have moved on
                nextState = isStore ? MEMWRITE : MEMREAD;
            end
            MEMREAD:     nextState = MEMWB;
            MEMWB:       nextState = FETCH;
            MEMWRITE:    nextState = FETCH;
            EXECR:       nextState = ALUWB;
            EXECI:       nextState = ALUWB;
            ALUWB:       nextState = FETCH;
            BEQ:         nextState = BRANCHCHECK;
            BRANCHCHECK: nextState = FETCH;
            // sticky until reset
            FAULT:       nextState = FAULT;
            default:     nextState = FAULT;
        endcase
    end

    // state register and instruction class
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state   <= FETCH;
            isStore <= 1'b0;
        end
        else
        begin
            state <= nextState;
            if (state == DECODE)
            begin
                isStore <= (instr.opcode == STORE);
            end
        end
    end

    // ALU op held from decode through the execute state
    always_ff @(posedge clk)
    begin
        if (state == DECODE)
        begin
            heldAluOp <= aluOp;
        end
    end

    // once faulted, only reset brings the FSM back
    faultSticky: assert property (
        @(posedge clk) disable iff (reset)
        state == FAULT |=> state == FAULT
    ) else $error("state left FAULT without reset");

    // register never holds one of the four spare codes
    stateLegal: assert property (
        @(posedge clk) disable iff (reset)
        state inside {FETCH, DECODE, MEMADDR, MEMREAD, MEMWB, MEMWRITE,
                      EXECR, EXECI, ALUWB, BEQ, BRANCHCHECK, FAULT}
    ) else $error("state holds an unused encoding");

endmodule

//--- hw/aluDecoder.sv
// ***************************************
// ALU decoder: opcode and funct fields to
// ALU operation plus an illegal flag
// ***************************************
`timescale 1ns/1ps

module aluDecoder
    import ctrlPkg::*;
(
    input  instrFields_t instr,
    output aluOp_e       aluOp,
    output logic         illegal
);

    always_comb
    begin
        aluOp   = ADD;
        illegal = 1'b0;
        case (instr.opcode)
            // address and compare setup use add, nop does not care
            LOAD, STORE, BRANCH, NOP:
            begin
                aluOp = ADD;
            end
            OPREG:
            begin
                case (instr.funct3)
                    F3_ADD:  aluOp = (instr.funct7 == FUNCT7_ALT) ? SUB : ADD;
                    F3_SLT:  aluOp = SLT;
                    F3_OR:   aluOp = OR;
                    F3_AND:  aluOp = AND;
                    // shifts, sltu, xor
                    default: illegal = 1'b1;
                endcase
                // alt funct7 is only legal together with add
                if (instr.funct7 != FUNCT7_BASE &&
                    !(instr.funct3 == F3_ADD && instr.funct7 == FUNCT7_ALT))
                begin
                    illegal = 1'b1;
                end
            end
            OPIMM:
            begin
                // funct7 is part of the immediate here
                case (instr.funct3)
                    F3_ADD:  aluOp = ADD;
                    F3_SLT:  aluOp = SLT;
                    F3_OR:   aluOp = OR;
                    F3_AND:  aluOp = AND;
                    // sltiu, xori, shifts not supported
                    default: illegal = 1'b1;
                endcase
            end
            // jal has no states in this controller
            JAL:
            begin
                illegal = 1'b1;
            end
            default:
            begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

//--- hw/ctrlPkg.sv
// ***************************************
// control unit package: opcodes, state and
// mux select enums, instruction fields and
// the control word steering the datapath
// ***************************************
package ctrlPkg;

    // instruction field widths
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;
    localparam int FUNCT7_W = 7;

    // funct7 codes, alt turns add into sub
    localparam logic [FUNCT7_W-1:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [FUNCT7_W-1:0] FUNCT7_ALT  = 7'b0100000;

    // funct3 codes common to R-type and I-type
    localparam logic [FUNCT3_W-1:0] F3_ADD = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_SLT = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_OR  = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_AND = 3'b111;

    typedef enum logic [OPCODE_W-1:0] {
        NOP    = 7'b0000000,
        LOAD   = 7'b0000011,
        OPIMM  = 7'b0010011,
        STORE  = 7'b0100011,
        OPREG  = 7'b0110011,
        BRANCH = 7'b1100011,
        // named so decode can reject it
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        FETCH       = 4'd0,
        DECODE      = 4'd1,
        MEMADDR     = 4'd2,
        MEMREAD     = 4'd3,
        MEMWB       = 4'd4,
        MEMWRITE    = 4'd5,
        EXECR       = 4'd6,
        EXECI       = 4'd7,
        ALUWB       = 4'd8,
        BEQ         = 4'd9,
        BRANCHCHECK = 4'd10,
        FAULT       = 4'd11
    } ctrlState_e;

    // codes understood by the external ALU
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        SLT = 3'd5
    } aluOp_e;

    typedef enum logic [1:0] {A_PC = 2'd0, A_OLDPC = 2'd1, A_REG = 2'd2} aluSrcA_e;
    typedef enum logic [1:0] {B_REG = 2'd0, B_IMM = 2'd1, B_FOUR = 2'd2} aluSrcB_e;
    typedef enum logic [1:0] {ALUOUT = 2'd0, DATA = 2'd1, ALURESULT = 2'd2} resultSrc_e;
    typedef enum logic [1:0] {ITYPE = 2'd0, STYPE = 2'd1, BTYPE = 2'd2} immSrc_e;

    // slice of the instruction register the controller looks at
    typedef struct packed {
        logic [OPCODE_W-1:0] opcode;
        logic [FUNCT3_W-1:0] funct3;
        logic [FUNCT7_W-1:0] funct7;
    } instrFields_t;

    // one Moore output word per state
    typedef struct packed {
        logic       pcWrite;
        logic       adrSrc;
        logic       memWrite;
        logic       irWrite;
        resultSrc_e resultSrc;
        aluOp_e     aluControl;
        aluSrcB_e   aluSrcB;
        aluSrcA_e   aluSrcA;
        immSrc_e    immSrc;
        logic       regWrite;
    } ctrlWord_t;

    // all strobes low, all selects at their zero code
    localparam ctrlWord_t IDLE_WORD = '0;

    // read instruction at PC, PC + 4 straight onto the result bus
    localparam ctrlWord_t FETCH_WORD = '{
        pcWrite:    1'b1,
        adrSrc:     1'b0,
        memWrite:   1'b0,
        irWrite:    1'b1,
        resultSrc:  ALURESULT,
        aluControl: ADD,
        aluSrcB:    B_FOUR,
        aluSrcA:    A_PC,
        immSrc:     ITYPE,
        regWrite:   1'b0
    };

endpackage
